// ==== sim.f ====
+incdir+sim
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_divider.sv
verilog/ex_stage_reg.sv
verilog/ex_stage_top.sv
sim/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_ex_stage \
    -Mdir "$OBJ" -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"$OBJ/tb_ex_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim/tb_ex_model.svh ====
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// one expected output pair
typedef struct packed {
    ex_pkg::pc_t      pc;
    ex_pkg::reg_idx_t rd0;
    ex_pkg::reg_idx_t rd1;
    ex_pkg::word_t    data0;
    ex_pkg::word_t    data1;
    logic             data0_valid;
    logic             data1_valid;
} exp_pair_t;

// accepted pairs not yet delivered, oldest first
exp_pair_t exp_q[$];

// integer ops straight from the instruction definitions
function automatic ex_pkg::word_t model_alu(input ex_pkg::alu_op_t op,
                                            input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
    ex_pkg::word_t r;
    case (op)
        ex_pkg::op_add:  r = a + b;
        ex_pkg::op_sub:  r = a - b;
        ex_pkg::op_and:  r = a & b;
        ex_pkg::op_or:   r = a | b;
        ex_pkg::op_xor:  r = a ^ b;
        // only the low five bits count as shift amount
        ex_pkg::op_sll:  r = a << b[4:0];
        ex_pkg::op_srl:  r = a >> b[4:0];
        ex_pkg::op_sra:  r = $unsigned($signed(a) >>> b[4:0]);
        ex_pkg::op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ex_pkg::op_sltu: r = (a < b) ? 32'd1 : 32'd0;
        default:         r = 32'd0;
    endcase
    return r;
endfunction

// divide on magnitudes, then apply the sign rules
function automatic ex_pkg::word_t model_div(input ex_pkg::alu_op_t op,
                                            input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
    logic          sgn;
    logic          a_neg;
    logic          b_neg;
    ex_pkg::word_t a_mag;
    ex_pkg::word_t b_mag;
    ex_pkg::word_t q;
    ex_pkg::word_t r;
    sgn   = (op == ex_pkg::op_div) || (op == ex_pkg::op_mod);
    a_neg = sgn && a[31];
    b_neg = sgn && b[31];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    if (b == 32'd0) begin
        // divide by zero: all ones, remainder is the dividend
        q = 32'hffff_ffff;
        r = a;
    end else begin
        q = a_mag / b_mag;
        r = a_mag % b_mag;
        if (a_neg ^ b_neg) begin
            q = -q;
        end
        // remainder follows the dividend
        if (a_neg) begin
            r = -r;
        end
    end
    return ((op == ex_pkg::op_mod) || (op == ex_pkg::op_modu)) ? r : q;
endfunction

// {valid, data} of one lane, has_div only on lane 0
function automatic logic [32:0] model_lane(input logic has_div,
                                           input logic en,
                                           input ex_pkg::alu_op_t op,
                                           input ex_pkg::word_t a,
                                           input ex_pkg::word_t b);
    if (!en) begin
        return 33'd0;
    end
    if (ex_pkg::is_div_op(op)) begin
        return has_div ? {1'b1, model_div(op, a, b)} : 33'd0;
    end
    return {1'b1, model_alu(op, a, b)};
endfunction

`endif

// ==== sim/tb_ex_stage.sv ====
`timescale 1ns/10ps

module tb_ex_stage;

    localparam int NUM_PAIRS    = 400;
    // a divide plus a few stall cycles
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 20;
    localparam int RUN_LIMIT    = 40000;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             issue_valid;
    logic             issue_ready;
    ex_pkg::pc_t      pc;
    ex_pkg::alu_op_t  op0;
    ex_pkg::word_t    src_a0;
    ex_pkg::word_t    src_b0;
    ex_pkg::reg_idx_t rd0;
    logic             lane0_en;
    ex_pkg::alu_op_t  op1;
    ex_pkg::word_t    src_a1;
    ex_pkg::word_t    src_b1;
    ex_pkg::reg_idx_t rd1;
    logic             lane1_en;
    logic             out_ready;
    logic             out_valid;
    ex_pkg::pc_t      out_pc;
    ex_pkg::reg_idx_t out_rd0;
    ex_pkg::word_t    out_data0;
    logic             out_data0_valid;
    ex_pkg::reg_idx_t out_rd1;
    ex_pkg::word_t    out_data1;
    logic             out_data1_valid;

    // stimulus state and counters
    logic [31:0] lfsr_state;
    ex_pkg::pc_t next_pc;
    logic        pair_pending;
    logic        expect_out;
    logic        stalled_prev;
    logic        timed_out;
    int          wait_cnt;
    int          error_count;
    int          accepted;
    int          delivered;
    int          dropped;

    `include "tb_ex_model.svh"

    ex_stage_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .pc              (pc),
        .op0             (op0),
        .src_a0          (src_a0),
        .src_b0          (src_b0),
        .rd0             (rd0),
        .lane0_en        (lane0_en),
        .op1             (op1),
        .src_a1          (src_a1),
        .src_b1          (src_b1),
        .rd1             (rd1),
        .lane1_en        (lane1_en),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_rd0         (out_rd0),
        .out_data0       (out_data0),
        .out_data0_valid (out_data0_valid),
        .out_rd1         (out_rd1),
        .out_data1       (out_data1),
        .out_data1_valid (out_data1_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // half of the operands are corner values
    function automatic ex_pkg::word_t pick_operand();
        logic [31:0]   kind;
        ex_pkg::word_t v;
        kind = rand_bits(3);
        case (kind)
            32'd0:   v = 32'h0000_0000;
            32'd1:   v = 32'hffff_ffff;
            32'd2:   v = 32'h8000_0000;
            32'd3:   v = 32'h0000_0001;
            default: v = rand_bits(32);
        endcase
        return v;
    endfunction

    // codes 14 and 15 fold onto div and divu
    function automatic ex_pkg::alu_op_t pick_op();
        logic [31:0] r;
        r = rand_bits(4);
        if (r > 32'd13) begin
            r = r - 32'd4;
        end
        return ex_pkg::alu_op_t'(r[3:0]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // new random pair on the issue side
    task automatic load_pair();
        logic [31:0] r;
        pc       = next_pc;
        next_pc  = next_pc + 32'd8;
        op0      = pick_op();
        op1      = pick_op();
        src_a0   = pick_operand();
        src_b0   = pick_operand();
        src_a1   = pick_operand();
        src_b1   = pick_operand();
        r        = rand_bits(10);
        rd0      = r[4:0];
        rd1      = r[9:5];
        r        = rand_bits(3);
        lane0_en = (r != 32'd0);
        r        = rand_bits(3);
        lane1_en = (r != 32'd0);
        wait_cnt = 0;
    endtask

    // handshakes seen just before the rising edge
    task automatic observe_cycle();
        exp_pair_t   want;
        logic [32:0] lane_res;
        // an accepted pair shows one edge later
        if (expect_out && !flush) begin
            check_value("out_valid after accept", 32'(out_valid), 32'd1);
        end
        expect_out   = 1'b0;
        stalled_prev = out_valid && !out_ready;
        if (stalled_prev) begin
            check_value("issue_ready under back-pressure", 32'(issue_ready), 32'd0);
        end
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Output transfer at %0t ns with no pair in flight", $time);
            end else begin
                want = exp_q.pop_front();
                delivered++;
                check_value("out_pc", out_pc, want.pc);
                check_value($sformatf("out_rd0 of pc %h", want.pc), 32'(out_rd0), 32'(want.rd0));
                check_value($sformatf("out_rd1 of pc %h", want.pc), 32'(out_rd1), 32'(want.rd1));
                check_value($sformatf("out_data0 of pc %h", want.pc), out_data0, want.data0);
                check_value($sformatf("out_data1 of pc %h", want.pc), out_data1, want.data1);
                check_value($sformatf("out_data0_valid of pc %h", want.pc),
                            32'(out_data0_valid), 32'(want.data0_valid));
                check_value($sformatf("out_data1_valid of pc %h", want.pc),
                            32'(out_data1_valid), 32'(want.data1_valid));
            end
        end
        if (issue_valid && issue_ready) begin
            // a lane 0 divide needs all its iterations first
            if (lane0_en && ex_pkg::is_div_op(op0)) begin
                check_value("divide accepted early", 32'(wait_cnt > ex_pkg::DIV_STEPS), 32'd1);
            end
            want.pc          = pc;
            want.rd0         = rd0;
            want.rd1         = rd1;
            lane_res         = model_lane(1'b1, lane0_en, op0, src_a0, src_b0);
            want.data0_valid = lane_res[32];
            want.data0       = lane_res[31:0];
            lane_res         = model_lane(1'b0, lane1_en, op1, src_a1, src_b1);
            want.data1_valid = lane_res[32];
            want.data1       = lane_res[31:0];
            exp_q.push_back(want);
            accepted++;
            pair_pending = 1'b0;
            expect_out   = 1'b1;
        end else if (issue_valid) begin
            wait_cnt++;
            if (wait_cnt > ACCEPT_LIMIT) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: pair at pc %h not accepted within %0d cycles",
                         pc, ACCEPT_LIMIT);
            end
        end
        // flush kills the stored pair and the one on issue
        if (flush) begin
            dropped += exp_q.size();
            exp_q.delete();
            pair_pending = 1'b0;
        end
    endtask

    initial begin
        int          n;
        logic [31:0] r;
        lfsr_state   = 32'h190d;
        next_pc      = 32'h0000_1000;
        pair_pending = 1'b0;
        expect_out   = 1'b0;
        stalled_prev = 1'b0;
        timed_out    = 1'b0;
        wait_cnt     = 0;
        error_count  = 0;
        accepted     = 0;
        delivered    = 0;
        dropped      = 0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        out_ready    = 1'b0;
        pc           = 32'd0;
        op0          = ex_pkg::op_add;
        op1          = ex_pkg::op_add;
        src_a0       = 32'd0;
        src_b0       = 32'd0;
        src_a1       = 32'd0;
        src_b1       = 32'd0;
        rd0          = 5'd0;
        rd1          = 5'd0;
        lane0_en     = 1'b0;
        lane1_en     = 1'b0;
        // nothing may come out during reset
        for (n = 0; n < 16; n++) begin
            @(negedge clk);
            check_value("out_valid in reset", 32'(out_valid), 32'd0);
        end
        rst_n     = 1'b1;
        out_ready = 1'b1;
        // idle with the sink ready
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            #1;
            observe_cycle();
        end
        n = 0;
        while (accepted < NUM_PAIRS && !timed_out) begin
            @(negedge clk);
            if (!pair_pending) begin
                r = rand_bits(2);
                if (r != 32'd0) begin
                    load_pair();
                    pair_pending = 1'b1;
                end
            end
            issue_valid = pair_pending;
            r           = rand_bits(2);
            out_ready   = (r != 32'd0);
            r           = rand_bits(7);
            flush       = (r == 32'd0);
            #1;
            observe_cycle();
            n++;
            if (n > RUN_LIMIT) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: only %0d pairs accepted in %0d cycles", accepted, RUN_LIMIT);
            end
        end
        // let the last pair out
        n = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(negedge clk);
            issue_valid = 1'b0;
            flush       = 1'b0;
            out_ready   = 1'b1;
            #1;
            observe_cycle();
            n++;
            if (n > DRAIN_LIMIT) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: %0d pairs never left the stage", exp_q.size());
            end
        end
        $display("Summary: %0d accepted, %0d delivered, %0d dropped by flush, %0d errors",
                 accepted, delivered, dropped, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/ex_stage_top.sv ====
`timescale 1ns/10ps

module ex_stage_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             issue_valid,
    output logic             issue_ready,
    input  ex_pkg::pc_t      pc,
    input  ex_pkg::alu_op_t  op0,
    input  ex_pkg::word_t    src_a0,
    input  ex_pkg::word_t    src_b0,
    input  ex_pkg::reg_idx_t rd0,
    input  logic             lane0_en,
    input  ex_pkg::alu_op_t  op1,
    input  ex_pkg::word_t    src_a1,
    input  ex_pkg::word_t    src_b1,
    input  ex_pkg::reg_idx_t rd1,
    input  logic             lane1_en,
    input  logic             out_ready,
    output logic             out_valid,
    output ex_pkg::pc_t      out_pc,
    output ex_pkg::reg_idx_t out_rd0,
    output ex_pkg::word_t    out_data0,
    output logic             out_data0_valid,
    output ex_pkg::reg_idx_t out_rd1,
    output ex_pkg::word_t    out_data1,
    output logic             out_data1_valid
);

    // lane results into the stage register
    ex_pkg::word_t alu_result0;
    ex_pkg::word_t alu_result1;
    logic          alu_valid0;
    logic          alu_valid1;

    // divider handshake
    logic          div_start;
    logic          div_signed;
    logic          div_ack;
    logic          div_done;
    ex_pkg::word_t quotient;
    ex_pkg::word_t remainder;

    ex_alu lane0_alu (
        .op           (op0),
        .src_a        (src_a0),
        .src_b        (src_b0),
        .result       (alu_result0),
        .result_valid (alu_valid0)
    );

    ex_alu lane1_alu (
        .op           (op1),
        .src_a        (src_a1),
        .src_b        (src_b1),
        .result       (alu_result1),
        .result_valid (alu_valid1)
    );

    // lane 0 operands go straight to the divider
    ex_divider lane0_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .div_start  (div_start),
        .div_signed (div_signed),
        .dividend   (src_a0),
        .divisor    (src_b0),
        .div_ack    (div_ack),
        .div_busy   (),
        .div_done   (div_done),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    ex_stage_reg stage_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .pc              (pc),
        .op0             (op0),
        .rd0             (rd0),
        .rd1             (rd1),
        .lane0_en        (lane0_en),
        .lane1_en        (lane1_en),
        .alu_result0     (alu_result0),
        .alu_result1     (alu_result1),
        .alu_valid0      (alu_valid0),
        .alu_valid1      (alu_valid1),
        .div_start       (div_start),
        .div_signed      (div_signed),
        .div_ack         (div_ack),
        .div_done        (div_done),
        .quotient        (quotient),
        .remainder       (remainder),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_rd0         (out_rd0),
        .out_rd1         (out_rd1),
        .out_data0       (out_data0),
        .out_data1       (out_data1),
        .out_data0_valid (out_data0_valid),
        .out_data1_valid (out_data1_valid)
    );

endmodule

// ==== verilog/ex_stage_reg.sv ====
`timescale 1ns/10ps

module ex_stage_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             issue_valid,
    output logic             issue_ready,
    input  ex_pkg::pc_t      pc,
    input  ex_pkg::alu_op_t  op0,
    input  ex_pkg::reg_idx_t rd0,
    input  ex_pkg::reg_idx_t rd1,
    input  logic             lane0_en,
    input  logic             lane1_en,
    input  ex_pkg::word_t    alu_result0,
    input  ex_pkg::word_t    alu_result1,
    input  logic             alu_valid0,
    input  logic             alu_valid1,
    output logic             div_start,
    output logic             div_signed,
    output logic             div_ack,
    input  logic             div_done,
    input  ex_pkg::word_t    quotient,
    input  ex_pkg::word_t    remainder,
    input  logic             out_ready,
    output logic             out_valid,
    output ex_pkg::pc_t      out_pc,
    output ex_pkg::reg_idx_t out_rd0,
    output ex_pkg::reg_idx_t out_rd1,
    output ex_pkg::word_t    out_data0,
    output ex_pkg::word_t    out_data1,
    output logic             out_data0_valid,
    output logic             out_data1_valid
);

    logic          valid_q;
    logic          div_pending_q;
    logic          lane0_div;
    logic          is_mod;
    logic          accept;
    logic          drain;
    ex_pkg::word_t data0_next;
    ex_pkg::word_t data1_next;
    logic          data0_valid_next;
    logic          data1_valid_next;

    // lane 0 waits on the divider only when enabled
    assign lane0_div  = lane0_en & ex_pkg::is_div_op(op0);
    assign is_mod     = (op0 == ex_pkg::op_mod) || (op0 == ex_pkg::op_modu);
    assign div_signed = (op0 == ex_pkg::op_div) || (op0 == ex_pkg::op_mod);

    // kick the divider once per pair
    assign div_start = issue_valid & lane0_div & ~div_pending_q & ~div_done & ~flush;

    // room when empty or emptying, divide result ready if needed
    assign issue_ready = ~flush & (~valid_q | out_ready) & (~lane0_div | div_done);
    assign accept      = issue_valid & issue_ready;
    assign div_ack     = accept & lane0_div;

    // flush kills the pair in the same cycle
    assign out_valid = valid_q & ~flush;
    assign drain     = out_valid & out_ready;

    always_comb begin
        // mod ops take the remainder
        if (lane0_div) begin
            data0_next       = is_mod ? remainder : quotient;
            data0_valid_next = 1'b1;
        end else begin
            data0_valid_next = lane0_en & alu_valid0;
            data0_next       = data0_valid_next ? alu_result0 : '0;
        end
        // lane 1 has no divider, so alu_valid1 already drops divides
        data1_valid_next = lane1_en & alu_valid1;
        data1_next       = data1_valid_next ? alu_result1 : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q         <= 1'b0;
            div_pending_q   <= 1'b0;
            out_data0_valid <= 1'b0;
            out_data1_valid <= 1'b0;
        end else if (flush) begin
            valid_q         <= 1'b0;
            div_pending_q   <= 1'b0;
            out_data0_valid <= 1'b0;
            out_data1_valid <= 1'b0;
        end else begin
            if (accept) begin
                valid_q         <= 1'b1;
                out_data0_valid <= data0_valid_next;
                out_data1_valid <= data1_valid_next;
            end else if (drain) begin
                // bubble when nothing follows
                valid_q <= 1'b0;
            end
            if (div_start) begin
                div_pending_q <= 1'b1;
            end else if (div_ack) begin
                div_pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            out_pc    <= ex_pkg::INST_NOP_PC;
            out_rd0   <= '0;
            out_rd1   <= '0;
            out_data0 <= '0;
            out_data1 <= '0;
        end else if (accept) begin
            out_pc    <= pc;
            out_rd0   <= rd0;
            out_rd1   <= rd1;
            out_data0 <= data0_next;
            out_data1 <= data1_next;
        end
    end

    // results hold while the next stage stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data0) && $stable(out_data1));

endmodule

// ==== verilog/ex_divider.sv ====
`timescale 1ns/10ps

module ex_divider (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          div_start,
    input  logic          div_signed,
    input  ex_pkg::word_t dividend,
    input  ex_pkg::word_t divisor,
    input  logic          div_ack,
    output logic          div_busy,
    output logic          div_done,
    output ex_pkg::word_t quotient,
    output ex_pkg::word_t remainder
);

    ex_pkg::div_state_t           state_q;
    logic [ex_pkg::DIV_CNT_W-1:0] cnt_q;

    // magnitude datapath
    ex_pkg::word_t rem_q;
    ex_pkg::word_t quo_q;
    ex_pkg::word_t dvsr_q;
    logic          neg_quo_q;
    logic          neg_rem_q;

    // operand magnitudes at start
    logic          dvnd_neg;
    logic          dvsr_neg;
    ex_pkg::word_t dvnd_mag;
    ex_pkg::word_t dvsr_mag;

    // one restoring step
    logic [32:0]   shifted;
    logic          take;
    ex_pkg::word_t rem_step;
    ex_pkg::word_t quo_step;

    assign dvnd_neg = div_signed & dividend[31];
    assign dvsr_neg = div_signed & divisor[31];
    assign dvnd_mag = dvnd_neg ? -dividend : dividend;
    assign dvsr_mag = dvsr_neg ? -divisor : divisor;

    always_comb begin
        // bring down the next dividend bit
        shifted  = {rem_q, quo_q[31]};
        take     = (shifted >= {1'b0, dvsr_q});
        rem_step = take ? ex_pkg::word_t'(shifted - {1'b0, dvsr_q}) : shifted[31:0];
        quo_step = {quo_q[30:0], take};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ex_pkg::div_idle;
            cnt_q   <= '0;
        end else if (flush) begin
            // drop any divide in flight
            state_q <= ex_pkg::div_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ex_pkg::div_idle: begin
                    if (div_start) begin
                        state_q <= ex_pkg::div_run;
                        cnt_q   <= '0;
                    end
                end
                ex_pkg::div_run: begin
                    cnt_q <= cnt_q + 1'b1;
                    // last iteration lands in done
                    if (cnt_q == ex_pkg::DIV_CNT_W'(ex_pkg::DIV_STEPS - 1)) begin
                        state_q <= ex_pkg::div_done;
                    end
                end
                ex_pkg::div_done: begin
                    // held until the stage register takes the pair
                    if (div_ack) begin
                        state_q <= ex_pkg::div_idle;
                    end
                end
                default: begin
                    state_q <= ex_pkg::div_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ex_pkg::div_idle && div_start) begin
            // quotient register starts as the dividend magnitude
            rem_q     <= '0;
            quo_q     <= dvnd_mag;
            dvsr_q    <= dvsr_mag;
            neg_quo_q <= dvnd_neg ^ dvsr_neg;
            neg_rem_q <= dvnd_neg;
        end else if (state_q == ex_pkg::div_run) begin
            rem_q <= rem_step;
            quo_q <= quo_step;
        end
    end

    assign div_busy = (state_q == ex_pkg::div_run);
    assign div_done = (state_q == ex_pkg::div_done);

    // zero divisor gives all ones, remainder keeps the dividend
    assign quotient  = (dvsr_q == '0) ? '1 : (neg_quo_q ? -quo_q : quo_q);
    // remainder follows the dividend sign
    assign remainder = neg_rem_q ? -rem_q : rem_q;

    // stage register must wait for idle before starting again
    assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> !div_busy && !div_done);

endmodule

// ==== verilog/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu (
    input  ex_pkg::alu_op_t op,
    input  ex_pkg::word_t   src_a,
    input  ex_pkg::word_t   src_b,
    output ex_pkg::word_t   result,
    output logic            result_valid
);

    // shift amount from the low five bits only
    logic [4:0] shamt;

    // shared adder result for add and sub
    ex_pkg::word_t sum;
    ex_pkg::word_t addend;

    assign shamt = src_b[4:0];

    // subtract as add of the inverted operand plus one
    assign addend = (op == ex_pkg::op_sub) ? ~src_b : src_b;
    assign sum    = src_a + addend + {31'd0, (op == ex_pkg::op_sub)};

    always_comb begin
        // divide ops belong to the divider
        result_valid = !ex_pkg::is_div_op(op);
        result       = '0;
        case (op)
            ex_pkg::op_add,
            ex_pkg::op_sub: begin
                result = sum;
            end
            ex_pkg::op_and: begin
                result = src_a & src_b;
            end
            ex_pkg::op_or: begin
                result = src_a | src_b;
            end
            ex_pkg::op_xor: begin
                result = src_a ^ src_b;
            end
            ex_pkg::op_sll: begin
                result = src_a << shamt;
            end
            ex_pkg::op_srl: begin
                result = src_a >> shamt;
            end
            ex_pkg::op_sra: begin
                // arithmetic shift keeps the sign bit
                result = ex_pkg::word_t'($signed(src_a) >>> shamt);
            end
            ex_pkg::op_slt: begin
                result = {31'd0, ($signed(src_a) < $signed(src_b))};
            end
            ex_pkg::op_sltu: begin
                result = {31'd0, (src_a < src_b)};
            end
            ex_pkg::op_div,
            ex_pkg::op_divu,
            ex_pkg::op_mod,
            ex_pkg::op_modu: begin
                // no result from this lane
                result = '0;
            end
            default: begin
                // unused encodings
                result       = '0;
                result_valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    // operand and result word
    typedef logic [31:0] word_t;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // program counter carried with the pair
    typedef logic [31:0] pc_t;

    // lane operation code
    // encodings are fixed so issue can send raw 4-bit codes
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_div  = 4'd10,
        op_divu = 4'd11,
        op_mod  = 4'd12,
        op_modu = 4'd13
    } alu_op_t;

    // iterative divider states
    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1,
        div_done = 2'd2
    } div_state_t;

    // one quotient bit per iteration
    localparam int DIV_STEPS = 32;

    // iteration counter width
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // pc value left behind by a flush
    localparam pc_t INST_NOP_PC = 32'h0000_0000;

    // the four ops served by the lane 0 divider
    function automatic logic is_div_op(alu_op_t op);
        return (op == op_div) || (op == op_divu) ||
               (op == op_mod) || (op == op_modu);
    endfunction

endpackage
